//--- sources.f
source/tanimoto_pkg.sv
source/batch_sequencer.sv
source/lane_scorer.sv
source/result_arbiter.sv
source/threshold_table.sv
source/pair_fifo.sv
source/tanimoto_top.sv
test/tb_tanimoto.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_tanimoto
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/tb_tanimoto.sv
module tb_tanimoto;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LANES      = 4;
    localparam int FIFO_DEPTH = 16;
    localparam int VW         = tanimoto_pkg::VECTOR_WIDTH;
    localparam int MAX_CMP    = 32;
    localparam int TIMEOUT    = 2000;

    logic                   clk;
    logic                   rstn;
    tanimoto_pkg::sub_word_t i_word;
    logic                   i_valid;
    logic                   i_last;
    logic                   i_thr_we;
    tanimoto_pkg::pop_t     i_thr_addr;
    tanimoto_pkg::pop_sum_t i_thr_data;
    logic                   i_pair_read;
    logic                   o_ready;
    logic                   o_pair_valid;
    tanimoto_pkg::id_pair_t o_pair;

    // Batch contents and the software copy of the threshold table
    logic [VW-1:0]          refs [LANES];
    logic [VW-1:0]          cmps [MAX_CMP];
    int                     num_cmp;
    tanimoto_pkg::pop_sum_t thr_model [VW+1];
    tanimoto_pkg::id_pair_t expected [$];
    logic                   stall;
    logic                   gaps;
    int                     checked;
    int                     value_errors;
    int                     other_errors;
    int unsigned            seed_val;

    tanimoto_top #(
        .LANES      (LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .clk          (clk),
        .rstn         (rstn),
        .i_word       (i_word),
        .i_valid      (i_valid),
        .i_last       (i_last),
        .i_thr_we     (i_thr_we),
        .i_thr_addr   (i_thr_addr),
        .i_thr_data   (i_thr_data),
        .i_pair_read  (i_pair_read),
        .o_ready      (o_ready),
        .o_pair_valid (o_pair_valid),
        .o_pair       (o_pair)
    );

    always #4 clk = ~clk;

    // Expected pairs of one batch in compare vector then lane order, closed by the end marker
    function automatic void expect_batch();
        tanimoto_pkg::id_pair_t pair;
        int n_and;
        int n_sum;
        for (int j = 0; j < num_cmp; j++) begin
            for (int l = 0; l < LANES; l++) begin
                n_and = $countones(refs[l] & cmps[j]);
                n_sum = $countones(refs[l]) + $countones(cmps[j]);
                if (n_sum <= int'(thr_model[n_and])) begin
                    pair.last   = 1'b0;
                    pair.ref_id = tanimoto_pkg::vec_id_t'(l);
                    pair.cmp_id = tanimoto_pkg::vec_id_t'(LANES + j);
                    expected.push_back(pair);
                end
            end
        end
        pair      = '0;
        pair.last = 1'b1;
        expected.push_back(pair);
    endfunction

    function automatic logic [VW-1:0] random_vector();
        return {$urandom(), $urandom()};
    endfunction

    task automatic check_pair(input tanimoto_pkg::id_pair_t got,
                              input tanimoto_pkg::id_pair_t exp);
        checked++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t o_pair got %0b/%0d/%0d expected %0b/%0d/%0d (last/ref/cmp)",
                     $time, got.last, got.ref_id, got.cmp_id, exp.last, exp.ref_id, exp.cmp_id);
        end
    endtask

    task automatic check_end(input tanimoto_pkg::id_pair_t got);
        tanimoto_pkg::id_pair_t exp;
        exp      = '0;
        exp.last = 1'b1;
        checked++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t o_pair got %0b/%0d/%0d expected end marker %0b/%0d/%0d",
                     $time, got.last, got.ref_id, got.cmp_id, exp.last, exp.ref_id, exp.cmp_id);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d entries checked, %0d value errors, %0d other errors",
                 checked, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic send_word(input tanimoto_pkg::sub_word_t word, input logic last);
        int waited;
        if (gaps) begin
            i_valid = 1'b0;
            repeat ($urandom_range(2, 0)) begin
                @(posedge clk);
                #1;
            end
        end
        i_word  = word;
        i_valid = 1'b1;
        i_last  = last;
        waited  = 0;
        // o_ready depends on registers only, so it is stable here
        while (!o_ready && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!o_ready) begin
            other_errors++;
            $display("ERROR: o_ready stayed low for %0d cycles", TIMEOUT);
            finish_run();
        end else begin
            @(posedge clk);
            #1;
            i_valid = 1'b0;
            i_last  = 1'b0;
        end
    endtask

    task automatic send_vector(input logic [VW-1:0] vec, input logic last);
        for (int s = 0; s < tanimoto_pkg::SUB_WORDS; s++) begin
            send_word(vec[s*tanimoto_pkg::BUS_WIDTH +: tanimoto_pkg::BUS_WIDTH],
                      last && (s == tanimoto_pkg::SUB_WORDS - 1));
        end
    endtask

    task automatic write_table();
        for (int a = 0; a <= VW; a++) begin
            i_thr_we   = 1'b1;
            i_thr_addr = tanimoto_pkg::pop_t'(a);
            i_thr_data = thr_model[a];
            @(posedge clk);
            #1;
        end
        i_thr_we = 1'b0;
    endtask

    task automatic run_batch(input string name);
        int waited;
        expect_batch();
        for (int l = 0; l < LANES; l++) begin
            send_vector(refs[l], 1'b0);
        end
        for (int j = 0; j < num_cmp; j++) begin
            send_vector(cmps[j], j == num_cmp - 1);
        end
        waited = 0;
        while (expected.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (expected.size() != 0) begin
            other_errors++;
            $display("ERROR: %0d entries of batch '%s' never arrived", expected.size(), name);
            finish_run();
        end else begin
            repeat (2) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // Reader pops o_pair whenever it is not stalled
    initial begin
        tanimoto_pkg::id_pair_t exp;
        forever begin
            @(posedge clk);
            #1;
            if (rstn && o_pair_valid && !stall) begin
                if (expected.size() == 0) begin
                    other_errors++;
                    $display("ERROR: o_pair carried an entry that no batch expects at %0t", $time);
                end else begin
                    exp = expected.pop_front();
                    if (exp.last) begin
                        check_end(o_pair);
                    end else begin
                        check_pair(o_pair, exp);
                    end
                end
                i_pair_read = 1'b1;
            end else begin
                i_pair_read = 1'b0;
            end
        end
    end

    initial begin
        seed_val      = $urandom(32'h368e_c7f5);
        clk           = 1'b0;
        rstn          = 1'b0;
        i_word        = '0;
        i_valid       = 1'b0;
        i_last        = 1'b0;
        i_thr_we      = 1'b0;
        i_thr_addr    = '0;
        i_thr_data    = '0;
        i_pair_read   = 1'b0;
        stall         = 1'b0;
        gaps          = 1'b0;
        checked       = 0;
        value_errors  = 0;
        other_errors  = 0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        // Hand-picked batch with a threshold for a similarity of at least one half
        for (int a = 0; a <= VW; a++) begin
            thr_model[a] = tanimoto_pkg::pop_sum_t'(3 * a);
        end
        write_table();
        refs[0] = 64'hFFFF_FFFF_0000_0000;
        refs[1] = 64'h0000_0000_FFFF_FFFF;
        refs[2] = 64'h00FF_00FF_00FF_00FF;
        refs[3] = 64'hAAAA_AAAA_AAAA_AAAA;
        cmps[0] = 64'hFFFF_FFFF_0000_0000;
        cmps[1] = 64'hFFFF_FFFF_FFFF_FFFF;
        cmps[2] = 64'h0000_0000_0000_0000;
        cmps[3] = 64'h0F0F_0F0F_0F0F_0F0F;
        num_cmp = 4;
        run_batch("hand-picked");

        // Random table and new references with IDs restarting from zero
        for (int a = 0; a <= VW; a++) begin
            thr_model[a] = tanimoto_pkg::pop_sum_t'(2 * a + $urandom_range(40, 0));
        end
        write_table();
        for (int l = 0; l < LANES; l++) begin
            refs[l] = random_vector();
        end
        num_cmp = 20;
        for (int j = 0; j < num_cmp; j++) begin
            cmps[j] = random_vector();
        end
        run_batch("random");

        // Same data again with idle cycles between sub-words
        gaps = 1'b1;
        run_batch("random with gaps");
        gaps = 1'b0;

        // Every pair passes, so the queue fills while the reader waits
        for (int a = 0; a <= VW; a++) begin
            thr_model[a] = '1;
        end
        write_table();
        for (int l = 0; l < LANES; l++) begin
            refs[l] = random_vector();
        end
        num_cmp = 6;
        for (int j = 0; j < num_cmp; j++) begin
            cmps[j] = random_vector();
        end
        stall = 1'b1;
        fork
            run_batch("stalled reader");
            begin
                repeat (300) @(posedge clk);
                #1;
                // Full queue holds the lanes pending, which keeps the input stalled
                if (o_ready) begin
                    other_errors++;
                    $display("ERROR: o_ready still high after the reader stalled for 300 cycles");
                end
                stall = 1'b0;
            end
        join

        repeat (10) @(posedge clk);
        #1;
        if (o_pair_valid) begin
            other_errors++;
            $display("ERROR: o_pair_valid still high after the last batch");
        end
        finish_run();
    end

endmodule

//--- source/tanimoto_top.sv
module tanimoto_top #(
    parameter int LANES      = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  tanimoto_pkg::sub_word_t i_word,
    input  logic                    i_valid,
    input  logic                    i_last,
    input  logic                    i_thr_we,
    input  tanimoto_pkg::pop_t      i_thr_addr,
    input  tanimoto_pkg::pop_sum_t  i_thr_data,
    input  logic                    i_pair_read,
    output logic                    o_ready,
    output logic                    o_pair_valid,
    output tanimoto_pkg::id_pair_t  o_pair
);

    tanimoto_pkg::broadcast_t         bcast;
    logic                             flush;
    logic                             lanes_busy;
    logic                             batch_done;
    logic [LANES-1:0]                 pending;
    tanimoto_pkg::score_t [LANES-1:0] scores;
    logic [LANES-1:0]                 grant;
    logic                             lookup;
    tanimoto_pkg::pop_t               lookup_addr;
    tanimoto_pkg::pop_sum_t           lookup_sum;
    logic                             thr_pass;
    logic                             fifo_we;
    tanimoto_pkg::id_pair_t           fifo_data;
    logic                             fifo_almost_full;
    logic                             fifo_empty;

    batch_sequencer #(
        .LANES (LANES)
    ) u_sequencer (
        .clk          (clk),
        .rstn         (rstn),
        .i_word       (i_word),
        .i_valid      (i_valid),
        .i_last       (i_last),
        .i_lanes_busy (lanes_busy),
        .i_batch_done (batch_done),
        .o_ready      (o_ready),
        .o_bcast      (bcast),
        .o_flush      (flush)
    );

    // Every lane sees the same sub-word in the same cycle
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        lane_scorer #(
            .LANE_ID (g)
        ) u_lane (
            .clk       (clk),
            .rstn      (rstn),
            .i_bcast   (bcast),
            .i_grant   (grant[g]),
            .o_pending (pending[g]),
            .o_score   (scores[g])
        );
    end

    result_arbiter #(
        .LANES (LANES)
    ) u_arbiter (
        .clk                (clk),
        .rstn               (rstn),
        .i_pending          (pending),
        .i_scores           (scores),
        .i_flush            (flush),
        .i_thr_pass         (thr_pass),
        .i_fifo_almost_full (fifo_almost_full),
        .o_grant            (grant),
        .o_lookup           (lookup),
        .o_lookup_addr      (lookup_addr),
        .o_lookup_sum       (lookup_sum),
        .o_fifo_we          (fifo_we),
        .o_fifo_data        (fifo_data),
        .o_lanes_busy       (lanes_busy),
        .o_batch_done       (batch_done)
    );

    threshold_table u_thr_table (
        .clk      (clk),
        .i_we     (i_thr_we),
        .i_waddr  (i_thr_addr),
        .i_wdata  (i_thr_data),
        .i_lookup (lookup),
        .i_addr   (lookup_addr),
        .i_sum    (lookup_sum),
        .o_pass   (thr_pass)
    );

    pair_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_pair_fifo (
        .clk           (clk),
        .rstn          (rstn),
        .i_we          (fifo_we),
        .i_data        (fifo_data),
        .i_re          (i_pair_read),
        .o_data        (o_pair),
        .o_empty       (fifo_empty),
        .o_almost_full (fifo_almost_full)
    );

    assign o_pair_valid = !fifo_empty;

endmodule

//--- source/pair_fifo.sv
module pair_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    i_we,
    input  tanimoto_pkg::id_pair_t  i_data,
    input  logic                    i_re,
    output tanimoto_pkg::id_pair_t  o_data,
    output logic                    o_empty,
    output logic                    o_almost_full
);

    localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    tanimoto_pkg::id_pair_t mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [CNT_WIDTH-1:0]   count;
    logic                   do_write;
    logic                   do_read;

    assign do_write = i_we && (count != CNT_WIDTH'(FIFO_DEPTH));
    assign do_read  = i_re && !o_empty;

    // Head entry is visible without a read strobe
    assign o_data        = mem[rd_ptr];
    assign o_empty       = (count == '0);
    assign o_almost_full = (count >= CNT_WIDTH'(FIFO_DEPTH - 2));

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- source/threshold_table.sv
module threshold_table (
    input  logic                    clk,
    input  logic                    i_we,
    input  tanimoto_pkg::pop_t      i_waddr,
    input  tanimoto_pkg::pop_sum_t  i_wdata,
    input  logic                    i_lookup,
    input  tanimoto_pkg::pop_t      i_addr,
    input  tanimoto_pkg::pop_sum_t  i_sum,
    output logic                    o_pass
);

    // One entry for every possible AND count
    localparam int DEPTH = 2 ** $bits(tanimoto_pkg::pop_t);

    tanimoto_pkg::pop_sum_t thr_mem [DEPTH];
    tanimoto_pkg::pop_sum_t thr_entry;

    // Entry holds the largest allowed cnt_ref + cnt_cmp for this AND count
    assign thr_entry = thr_mem[i_addr];

    always_ff @(posedge clk) begin
        if (i_we) begin
            thr_mem[i_waddr] <= i_wdata;
        end
    end

    // Pass bit is valid the cycle after the lookup strobe
    always_ff @(posedge clk) begin
        if (i_lookup) begin
            o_pass <= (i_sum <= thr_entry);
        end
    end

endmodule

//--- source/result_arbiter.sv
module result_arbiter #(
    parameter int LANES = 4
) (
    input  logic                                    clk,
    input  logic                                    rstn,
    input  logic [LANES-1:0]                        i_pending,
    input  tanimoto_pkg::score_t [LANES-1:0]        i_scores,
    input  logic                                    i_flush,
    input  logic                                    i_thr_pass,
    input  logic                                    i_fifo_almost_full,
    output logic [LANES-1:0]                        o_grant,
    output logic                                    o_lookup,
    output tanimoto_pkg::pop_t                      o_lookup_addr,
    output tanimoto_pkg::pop_sum_t                  o_lookup_sum,
    output logic                                    o_fifo_we,
    output tanimoto_pkg::id_pair_t                  o_fifo_data,
    output logic                                    o_lanes_busy,
    output logic                                    o_batch_done
);

    localparam int SEL_WIDTH = (LANES > 1) ? $clog2(LANES) : 1;

    logic [SEL_WIDTH-1:0]   sel;
    logic                   can_grant;
    logic                   lk_valid;
    tanimoto_pkg::vec_id_t  lk_ref_id;
    tanimoto_pkg::vec_id_t  lk_cmp_id;
    logic                   end_ok;

    assign o_lanes_busy = |i_pending;
    assign can_grant    = o_lanes_busy && !i_fifo_almost_full;

    // Lowest pending lane wins
    always_comb begin
        sel = '0;
        for (int i = LANES - 1; i >= 0; i--) begin
            if (i_pending[i]) begin
                sel = SEL_WIDTH'(i);
            end
        end
    end

    assign o_grant       = can_grant ? (LANES'(1) << sel) : '0;
    assign o_lookup      = can_grant;
    assign o_lookup_addr = i_scores[sel].cnt_and;
    assign o_lookup_sum  = tanimoto_pkg::pop_sum_t'(i_scores[sel].cnt_ref) +
                           tanimoto_pkg::pop_sum_t'(i_scores[sel].cnt_cmp);

    // IDs wait here while the table computes the pass bit
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lk_valid <= 1'b0;
        end else begin
            lk_valid <= can_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (can_grant) begin
            lk_ref_id <= i_scores[sel].ref_id;
            lk_cmp_id <= i_scores[sel].cmp_id;
        end
    end

    // End marker once every lane and the lookup stage have drained
    assign end_ok       = i_flush && !o_lanes_busy && !lk_valid && !i_fifo_almost_full;
    assign o_batch_done = end_ok;
    assign o_fifo_we    = (lk_valid && i_thr_pass) || end_ok;

    always_comb begin
        o_fifo_data.last   = end_ok;
        o_fifo_data.ref_id = end_ok ? '0 : lk_ref_id;
        o_fifo_data.cmp_id = end_ok ? '0 : lk_cmp_id;
    end

endmodule

//--- source/lane_scorer.sv
module lane_scorer #(
    parameter int LANE_ID = 0
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  tanimoto_pkg::broadcast_t  i_bcast,
    input  logic                      i_grant,
    output logic                      o_pending,
    output tanimoto_pkg::score_t      o_score
);

    tanimoto_pkg::sub_word_t ref_mem [tanimoto_pkg::SUB_WORDS];
    tanimoto_pkg::pop_t      ref_cnt;
    tanimoto_pkg::vec_id_t   ref_id;
    tanimoto_pkg::pop_t      and_acc;
    tanimoto_pkg::pop_t      and_base;
    tanimoto_pkg::pop_t      and_next;
    logic                    load_ref;
    logic                    compare;

    assign load_ref = i_bcast.valid && i_bcast.is_ref &&
                      (i_bcast.vec_id == tanimoto_pkg::vec_id_t'(LANE_ID));
    assign compare  = i_bcast.valid && !i_bcast.is_ref;

    // AND popcount of this sub-word added to the running total
    assign and_base = (i_bcast.sub_idx == '0) ? '0 : and_acc;
    assign and_next = and_base +
                      tanimoto_pkg::popcount(i_bcast.word & ref_mem[i_bcast.sub_idx]);

    always_ff @(posedge clk) begin
        if (load_ref) begin
            ref_mem[i_bcast.sub_idx] <= i_bcast.word;
            if (i_bcast.final_word) begin
                ref_cnt <= i_bcast.vec_cnt;
                ref_id  <= i_bcast.vec_id;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (compare) begin
            and_acc <= and_next;
            if (i_bcast.final_word) begin
                o_score.ref_id  <= ref_id;
                o_score.cmp_id  <= i_bcast.vec_id;
                o_score.cnt_ref <= ref_cnt;
                o_score.cnt_cmp <= i_bcast.vec_cnt;
                o_score.cnt_and <= and_next;
            end
        end
    end

    // Input is stalled while pending, so a grant never meets a new score
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_pending <= 1'b0;
        end else if (compare && i_bcast.final_word) begin
            o_pending <= 1'b1;
        end else if (i_grant) begin
            o_pending <= 1'b0;
        end
    end

endmodule

//--- source/batch_sequencer.sv
module batch_sequencer #(
    parameter int LANES = 4
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  tanimoto_pkg::sub_word_t   i_word,
    input  logic                      i_valid,
    input  logic                      i_last,
    input  logic                      i_lanes_busy,
    input  logic                      i_batch_done,
    output logic                      o_ready,
    output tanimoto_pkg::broadcast_t  o_bcast,
    output logic                      o_flush
);

    tanimoto_pkg::seq_state_e state;
    tanimoto_pkg::sub_idx_t   sub_idx;
    tanimoto_pkg::vec_id_t    vec_id;
    tanimoto_pkg::pop_t       cnt_acc;
    tanimoto_pkg::pop_t       cnt_base;
    tanimoto_pkg::pop_t       vec_cnt;
    logic                     accept;
    logic                     final_word;

    // Input stalls while any lane still holds an unscored result
    assign o_ready    = (state != tanimoto_pkg::FLUSH) && !i_lanes_busy;
    assign accept     = i_valid && o_ready;
    assign final_word = (sub_idx == tanimoto_pkg::sub_idx_t'(tanimoto_pkg::SUB_WORDS - 1));
    assign o_flush    = (state == tanimoto_pkg::FLUSH);

    // Running popcount of the vector that restarts on its first sub-word
    assign cnt_base = (sub_idx == '0) ? '0 : cnt_acc;
    assign vec_cnt  = cnt_base + tanimoto_pkg::popcount(i_word);

    always_comb begin
        o_bcast.valid      = accept;
        o_bcast.is_ref     = (state == tanimoto_pkg::LOAD_REF);
        o_bcast.sub_idx    = sub_idx;
        o_bcast.word       = i_word;
        o_bcast.final_word = final_word;
        o_bcast.vec_id     = vec_id;
        o_bcast.vec_cnt    = vec_cnt;
    end

    // Popcount of the sub-words accepted so far
    always_ff @(posedge clk) begin
        if (accept) begin
            cnt_acc <= vec_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= tanimoto_pkg::LOAD_REF;
            sub_idx <= '0;
            vec_id  <= '0;
        end else begin
            if (accept) begin
                if (final_word) begin
                    sub_idx <= '0;
                    vec_id  <= vec_id + 1'b1;
                end else begin
                    sub_idx <= sub_idx + 1'b1;
                end
            end
            case (state)
                tanimoto_pkg::LOAD_REF: begin
                    // After the last reference the rest of the batch is compared
                    if (accept && final_word &&
                        vec_id == tanimoto_pkg::vec_id_t'(LANES - 1)) begin
                        state <= tanimoto_pkg::COMPARE;
                    end
                end
                tanimoto_pkg::COMPARE: begin
                    if (accept && i_last) begin
                        state <= tanimoto_pkg::FLUSH;
                    end
                end
                tanimoto_pkg::FLUSH: begin
                    if (i_batch_done) begin
                        state   <= tanimoto_pkg::LOAD_REF;
                        sub_idx <= '0;
                        vec_id  <= '0;
                    end
                end
                default: begin
                    state <= tanimoto_pkg::LOAD_REF;
                end
            endcase
        end
    end

endmodule

//--- source/tanimoto_pkg.sv
package tanimoto_pkg;

    // Vector geometry
    localparam int BUS_WIDTH     = 32;
    localparam int VECTOR_WIDTH  = 64;
    localparam int SUB_WORDS     = VECTOR_WIDTH / BUS_WIDTH;
    localparam int VEC_ID_WIDTH  = 8;

    // Derived widths
    localparam int SUB_IDX_WIDTH = (SUB_WORDS > 1) ? $clog2(SUB_WORDS) : 1;
    localparam int POP_WIDTH     = $clog2(VECTOR_WIDTH + 1);

    typedef logic [BUS_WIDTH-1:0]     sub_word_t;
    typedef logic [SUB_IDX_WIDTH-1:0] sub_idx_t;
    typedef logic [POP_WIDTH-1:0]     pop_t;
    typedef logic [POP_WIDTH:0]       pop_sum_t;
    typedef logic [VEC_ID_WIDTH-1:0]  vec_id_t;

    typedef enum logic [1:0] {
        LOAD_REF = 2'b00,
        COMPARE  = 2'b01,
        FLUSH    = 2'b10
    } seq_state_e;

    // One accepted sub-word as seen by every lane
    typedef struct packed {
        logic      valid;
        logic      is_ref;
        sub_idx_t  sub_idx;
        sub_word_t word;
        logic      final_word;
        vec_id_t   vec_id;
        pop_t      vec_cnt;
    } broadcast_t;

    typedef struct packed {
        vec_id_t ref_id;
        vec_id_t cmp_id;
        pop_t    cnt_ref;
        pop_t    cnt_cmp;
        pop_t    cnt_and;
    } score_t;

    typedef struct packed {
        logic    last;
        vec_id_t ref_id;
        vec_id_t cmp_id;
    } id_pair_t;

    function automatic pop_t popcount(input sub_word_t word);
        pop_t cnt;
        cnt = '0;
        for (int i = 0; i < BUS_WIDTH; i++) begin
            cnt = cnt + pop_t'(word[i]);
        end
        return cnt;
    endfunction

endpackage
